//--- lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// byte address and data word widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// sram depth in words
// valid byte addresses run from 0 to 4*depth-1
`define LSU_MEM_WORDS 256

// cycles between an ar or w transfer and the matching response
// must be 1 or more
`define LSU_SRAM_LAT 2

`endif

//--- lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // access size code from the core
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } size_t;

    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        DONE
    } ctrl_state_t;

endpackage

//--- lsu_align.sv
`timescale 1ns/100ps

module lsu_align (
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::size_t size,
    input  logic           sign,
    input  lsu_pkg::data_t wdata,
    input  lsu_pkg::data_t mem_rdata,
    output lsu_pkg::strb_t wstrb,
    output lsu_pkg::data_t wdata_lane,
    output lsu_pkg::data_t rdata_ext
);

    // bit offset of the addressed byte lane
    logic [4:0]     lane_sh;
    lsu_pkg::data_t rd_shift;

    assign lane_sh = {addr[1:0], 3'b000};

    // store strobe, halfwords pick the upper or lower pair
    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: wstrb = 4'b0001 << addr[1:0];
            lsu_pkg::SIZE_HALF: wstrb = addr[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::SIZE_WORD: wstrb = 4'b1111;
            default:            wstrb = 4'b0000;
        endcase
    end

    // store data moved up into its lane
    assign wdata_lane = wdata << lane_sh;

    // load data moved down to bit 0
    assign rd_shift = mem_rdata >> lane_sh;

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                rdata_ext = {{24{sign & rd_shift[7]}}, rd_shift[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                rdata_ext = {{16{sign & rd_shift[15]}}, rd_shift[15:0]};
            end
            lsu_pkg::SIZE_WORD: begin
                rdata_ext = rd_shift;
            end
            // no lanes selected
            default: begin
                rdata_ext = '0;
            end
        endcase
    end

endmodule

//--- lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl (
    input  logic           clk,
    input  logic           rst,
    // core request
    input  logic           req,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::data_t wdata,
    output logic           busy,
    output logic           done,
    output logic           err,
    output lsu_pkg::data_t rdata,
    // bus master side
    output lsu_pkg::addr_t araddr,
    output logic           arvalid,
    input  logic           arready,
    input  lsu_pkg::data_t rdata_bus,
    input  lsu_pkg::resp_t rresp,
    input  logic           rvalid,
    output logic           rready,
    output lsu_pkg::addr_t awaddr,
    output logic           awvalid,
    input  logic           awready,
    output logic           wvalid,
    input  logic           wready,
    input  lsu_pkg::resp_t bresp,
    input  logic           bvalid,
    output logic           bready,
    // captured request towards the aligner
    output lsu_pkg::addr_t cap_addr,
    output lsu_pkg::size_t cap_size,
    output logic           cap_sign,
    output lsu_pkg::data_t cap_wdata,
    input  lsu_pkg::data_t rdata_ext
);

    lsu_pkg::ctrl_state_t state;
    lsu_pkg::ctrl_state_t state_nxt;
    logic                 accept;
    logic                 r_xfer;
    logic                 b_xfer;

    assign accept = (state == lsu_pkg::IDLE) && req;
    assign r_xfer = (state == lsu_pkg::RD_DATA) && rvalid;
    assign b_xfer = (state == lsu_pkg::WR_RESP) && bvalid;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (req) begin
                    // store wins over load, neither goes straight to done
                    if (wen) begin
                        state_nxt = lsu_pkg::WR_ADDR;
                    end else if (ren) begin
                        state_nxt = lsu_pkg::RD_ADDR;
                    end else begin
                        state_nxt = lsu_pkg::DONE;
                    end
                end
            end
            lsu_pkg::RD_ADDR: if (arready) state_nxt = lsu_pkg::RD_DATA;
            lsu_pkg::RD_DATA: if (rvalid) state_nxt = lsu_pkg::DONE;
            lsu_pkg::WR_ADDR: if (awready) state_nxt = lsu_pkg::WR_DATA;
            lsu_pkg::WR_DATA: if (wready) state_nxt = lsu_pkg::WR_RESP;
            lsu_pkg::WR_RESP: if (bvalid) state_nxt = lsu_pkg::DONE;
            default:          state_nxt = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
            err   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                err <= 1'b0;
            end else if (r_xfer) begin
                err <= (rresp == lsu_pkg::RESP_SLVERR);
            end else if (b_xfer) begin
                err <= (bresp == lsu_pkg::RESP_SLVERR);
            end
        end
    end

    // request capture and load result
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_addr  <= addr;
            cap_size  <= size;
            cap_sign  <= sign;
            cap_wdata <= wdata;
            rdata     <= '0;
        end
        if (r_xfer) begin
            rdata <= (rresp == lsu_pkg::RESP_SLVERR) ? '0 : rdata_ext;
        end
    end

    // valids and readys follow the state, so each drops on its transfer
    assign arvalid = (state == lsu_pkg::RD_ADDR);
    assign rready  = (state == lsu_pkg::RD_DATA);
    assign awvalid = (state == lsu_pkg::WR_ADDR);
    assign wvalid  = (state == lsu_pkg::WR_DATA);
    assign bready  = (state == lsu_pkg::WR_RESP);
    assign araddr  = cap_addr;
    assign awaddr  = cap_addr;
    assign busy    = (state != lsu_pkg::IDLE);
    assign done    = (state == lsu_pkg::DONE);

    a_one_addr: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid));
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid);
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid);
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid);
    // slave hands back zero on a failed read
    a_err_zero: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && rresp == lsu_pkg::RESP_SLVERR |-> rdata_bus == '0);

endmodule

//--- lsu_sram.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_sram (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`LSU_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`LSU_DATA_W-1:0]   rdata,
    output lsu_pkg::resp_t           rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [`LSU_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`LSU_DATA_W-1:0]   wdata,
    input  logic [`LSU_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output lsu_pkg::resp_t           bresp,
    output logic                     bvalid,
    input  logic                     bready
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = $clog2(`LSU_SRAM_LAT + 1);
    localparam logic [`LSU_ADDR_W-1:0] MEM_BYTES = `LSU_ADDR_W'(`LSU_MEM_WORDS * 4);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`LSU_SRAM_LAT - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_WAIT,
        S_RD_RESP,
        S_WR_DATA,
        S_WR_WAIT,
        S_WR_RESP
    } sram_state_t;

    logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
    sram_state_t            st;
    logic [CNT_W-1:0]       cnt;
    logic [`LSU_ADDR_W-1:0] addr_q;
    logic                   in_range;
    logic [IDX_W-1:0]       idx;
    logic                   lat_end;

    assign in_range = (addr_q < MEM_BYTES);
    assign idx      = addr_q[IDX_W+1:2];
    assign lat_end  = (cnt == '0);

    assign arready = (st == S_IDLE);
    assign awready = (st == S_IDLE);
    assign wready  = (st == S_WR_DATA);
    assign rvalid  = (st == S_RD_RESP);
    assign bvalid  = (st == S_WR_RESP);

    always_ff @(posedge clk) begin
        if (rst) begin
            st  <= S_IDLE;
            cnt <= '0;
        end else begin
            case (st)
                S_IDLE: begin
                    cnt <= CNT_LOAD;
                    // read first if both are offered
                    if (arvalid) begin
                        st <= S_RD_WAIT;
                    end else if (awvalid) begin
                        st <= S_WR_DATA;
                    end
                end
                S_WR_DATA: begin
                    cnt <= CNT_LOAD;
                    if (wvalid) st <= S_WR_WAIT;
                end
                S_RD_WAIT, S_WR_WAIT: begin
                    if (lat_end) begin
                        st <= (st == S_RD_WAIT) ? S_RD_RESP : S_WR_RESP;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_RD_RESP: if (rready) st <= S_IDLE;
                S_WR_RESP: if (bready) st <= S_IDLE;
                default:   st <= S_IDLE;
            endcase
        end
    end

    // address taken while idle, read word fetched as the wait ends
    always_ff @(posedge clk) begin
        if (st == S_IDLE) begin
            addr_q <= arvalid ? araddr : awaddr;
        end
        if (st == S_RD_WAIT && lat_end) begin
            rdata <= in_range ? mem[idx] : '0;
            rresp <= in_range ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end
        if (st == S_WR_DATA && wvalid) begin
            bresp <= in_range ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
            if (in_range) begin
                for (int i = 0; i < `LSU_DATA_W / 8; i++) begin
                    if (wstrb[i]) mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // write data must follow an accepted write address
    a_w_after_aw: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> st == S_WR_DATA);
    a_resp_excl: assert property (@(posedge clk) disable iff (rst)
        !(rvalid && bvalid));

endmodule

//--- lsu_top.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           req,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::data_t wdata,
    output lsu_pkg::data_t rdata,
    output logic           done,
    output logic           err,
    output logic           busy
);

    // bus between controller and sram
    logic [`LSU_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`LSU_DATA_W-1:0]   bus_rdata;
    lsu_pkg::resp_t           rresp;
    logic                     rvalid;
    logic                     rready;
    logic [`LSU_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`LSU_DATA_W-1:0]   wdata_lane;
    logic [`LSU_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    lsu_pkg::resp_t           bresp;
    logic                     bvalid;
    logic                     bready;

    // captured request and aligned load value
    lsu_pkg::addr_t cap_addr;
    lsu_pkg::size_t cap_size;
    logic           cap_sign;
    lsu_pkg::data_t cap_wdata;
    lsu_pkg::data_t rdata_ext;

    lsu_ctrl i_lsu_ctrl (
        .*,
        .rdata_bus (bus_rdata)
    );

    lsu_align i_lsu_align (
        .addr       (cap_addr),
        .size       (cap_size),
        .sign       (cap_sign),
        .wdata      (cap_wdata),
        .mem_rdata  (bus_rdata),
        .wstrb      (wstrb),
        .wdata_lane (wdata_lane),
        .rdata_ext  (rdata_ext)
    );

    lsu_sram i_lsu_sram (
        .*,
        .rdata (bus_rdata),
        .wdata (wdata_lane)
    );

endmodule

//--- tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;

    localparam int FIELDS   = 7;
    localparam int MAX_OPS  = 64;
    localparam int WAIT_MAX = 50;

    logic           clk;
    logic           rst;
    logic           req;
    logic           wen;
    logic           ren;
    logic           sign;
    lsu_pkg::size_t size;
    lsu_pkg::addr_t addr;
    lsu_pkg::data_t wdata;
    lsu_pkg::data_t rdata;
    logic           done;
    logic           err;
    logic           busy;

    // seven words per operation in the order op, size, sign, addr, wdata, rdata, err
    logic [31:0] stim [0:FIELDS*MAX_OPS-1];
    int          op_cnt;

    lsu_top i_lsu_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_MAX, what);
        $display("Verification failed");
        $fatal(1, "DUT did not respond");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) stop_on_timeout("busy to fall");
        end
    endtask

    // busy must stay high for the whole transaction
    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (!done) begin
            check_value({name, " busy"}, 32'd1, {31'd0, busy});
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) stop_on_timeout("done");
        end
    endtask

    task automatic run_op(input int idx);
        logic [31:0] op;
        logic [31:0] exp_rdata;
        logic [31:0] exp_err;
        string       name;
        op        = stim[idx*FIELDS];
        exp_rdata = stim[idx*FIELDS+5];
        exp_err   = stim[idx*FIELDS+6];
        name      = $sformatf("op %0d", idx);
        wait_idle();
        req   = 1'b1;
        wen   = (op == 32'd0);
        ren   = (op == 32'd1);
        size  = lsu_pkg::size_t'(stim[idx*FIELDS+1][1:0]);
        sign  = stim[idx*FIELDS+2][0];
        addr  = stim[idx*FIELDS+3];
        wdata = stim[idx*FIELDS+4];
        @(negedge clk);
        // request already captured so the core side may move on
        req   = 1'b0;
        wen   = 1'b0;
        ren   = 1'b0;
        size  = lsu_pkg::size_t'(~size);
        sign  = ~sign;
        addr  = ~addr;
        wdata = ~wdata;
        check_value({name, " busy after req"}, 32'd1, {31'd0, busy});
        wait_done(name);
        if (op == 32'd1) begin
            check_value({name, " rdata"}, exp_rdata, rdata);
        end
        check_value({name, " err"}, exp_err, {31'd0, err});
        @(negedge clk);
        check_value({name, " done pulse"}, 32'd0, {31'd0, done});
        check_value({name, " busy after done"}, 32'd0, {31'd0, busy});
    endtask

    initial begin
        rst   = 1'b1;
        req   = 1'b0;
        wen   = 1'b0;
        ren   = 1'b0;
        sign  = 1'b0;
        size  = lsu_pkg::SIZE_NONE;
        addr  = '0;
        wdata = '0;
        // unread entries look like an op code past the last valid one
        for (int i = 0; i < FIELDS*MAX_OPS; i++) begin
            stim[i] = '1;
        end
        $readmemh("lsu_stimulus.txt", stim);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset busy", 32'd0, {31'd0, busy});
        check_value("reset done", 32'd0, {31'd0, done});
        check_value("reset err", 32'd0, {31'd0, err});
        op_cnt = 0;
        while (op_cnt < MAX_OPS && stim[op_cnt*FIELDS] <= 32'd2) begin
            run_op(op_cnt);
            op_cnt++;
        end
        if (op_cnt == 0) begin
            $display("No operations were read from the stimulus file");
            $display("Verification failed");
            $fatal(1, "empty stimulus");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- lsu_stimulus.txt
// op (0 store, 1 load, 2 no-op)  size  sign  addr  wdata  expected rdata  expected err
// size 0 none, 1 byte, 2 half, 3 word; rdata is only checked for loads
0 3 0 00000000 12345678 00000000 0
0 3 0 00000004 cafef00d 00000000 0
0 3 0 000003fc a5a55a5a 00000000 0
1 3 0 00000000 00000000 12345678 0
1 3 0 00000004 00000000 cafef00d 0
1 3 0 000003fc 00000000 a5a55a5a 0
0 3 0 00000010 11223344 00000000 0
0 1 0 00000011 000000ab 00000000 0
0 2 0 00000012 0000beef 00000000 0
1 3 0 00000010 00000000 beefab44 0
0 3 0 00000020 89abcdef 00000000 0
0 1 0 00000023 ffffff11 00000000 0
1 3 0 00000020 00000000 11abcdef 0
1 1 1 00000011 00000000 ffffffab 0
1 1 0 00000011 00000000 000000ab 0
1 1 1 00000010 00000000 00000044 0
1 1 1 00000013 00000000 ffffffbe 0
1 1 0 00000012 00000000 000000ef 0
1 2 1 00000012 00000000 ffffbeef 0
1 2 0 00000012 00000000 0000beef 0
1 2 1 00000010 00000000 ffffab44 0
1 2 1 00000020 00000000 ffffcdef 0
1 2 1 00000022 00000000 000011ab 0
0 3 0 00000400 deadbeef 00000000 1
1 3 0 00000400 00000000 00000000 1
1 3 0 80000000 00000000 00000000 1
1 3 0 00000000 00000000 12345678 0
0 0 0 00000004 ffffffff 00000000 0
1 0 1 00000004 00000000 00000000 0
2 3 0 00000004 11111111 00000000 0
1 3 0 00000004 00000000 cafef00d 0

//--- compile.f
+incdir+.
lsu_pkg.sv
lsu_align.sv
lsu_ctrl.sv
lsu_sram.sv
lsu_top.sv
tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_lsu --Mdir obj_dir -o sim_tb_lsu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_lsu 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
